/* design/fp_add_sub.sv */
// Floating-point adder and subtractor, three pipeline stages
// Stage 1 aligns, stage 2 adds the significands, stage 3 normalizes
// Rounding is toward zero and denormal inputs count as zero

`timescale 1ns/1ns
`default_nettype none

module fp_add_sub (
    input  logic                         clock,
    input  logic                         rst_n,
    input  fp_alu_pkg::operand_stream_t  a,
    input  fp_alu_pkg::operand_stream_t  b,
    input  fp_alu_pkg::op_stream_t       operation,
    output fp_alu_pkg::result_stream_t   result
);
    import fp_alu_pkg::*;

    // Position of the first set bit, counted from the top of the raw sum
    function automatic logic [4:0] lead_zeros(input logic [27:0] value);
        logic [4:0] count;
        logic       found;
        count = 5'd0;
        found = 1'b0;
        for (int i = 27; i >= 0; i--) begin
            if (!found) begin
                if (value[i]) found = 1'b1;
                else count = count + 5'd1;
            end
        end
        return count;
    endfunction

    logic fire;

    // Unpacked operands after the denormal flush
    fp_fields_t a_f, b_f;
    logic       a_sign, b_sign;
    logic [7:0] a_exp, b_exp;
    logic [23:0] a_sig, b_sig;
    logic       a_larger;
    logic       big_sign;
    logic [7:0] big_exp, exp_diff;
    logic [26:0] big_ext, small_ext, lost_mask, small_aligned;
    logic       sticky;

    // Stage 1 registers
    logic        s1_sign, s1_eff_sub;
    logic [7:0]  s1_exp;
    logic [26:0] s1_big, s1_small;

    // Stage 2 registers, bit 27 of the sum is the carry out
    logic        s2_sign;
    logic [7:0]  s2_exp;
    logic [27:0] s2_sum;

    // Stage 3 normalization
    logic [4:0]  norm_shift;
    logic [27:0] norm_sum;
    logic [9:0]  norm_exp;
    fp_fields_t  norm_result;
    logic [31:0] s3_data;

    // Valid and tag ride in a delay line as long as the data path
    logic [add_latency-1:0] valid_q;
    logic [tag_width-1:0]   tag_q [add_latency];

    assign fire = a.valid & b.valid & operation.valid;

    always_comb begin
        a_f = a.data.as_fp;
        b_f = b.data.as_fp;
        a_exp = a_f.exponent;
        b_exp = b_f.exponent;
        // A zero exponent field means zero or denormal, both read as zero
        a_sig = (a_f.exponent == 8'd0) ? 24'd0 : {1'b1, a_f.mantissa};
        b_sig = (b_f.exponent == 8'd0) ? 24'd0 : {1'b1, b_f.mantissa};
        a_sign = a_f.sign;
        // Subtraction is addition with b negated
        b_sign = b_f.sign ^ operation.subtract;
        a_larger = {a_exp, a_sig} >= {b_exp, b_sig};
        big_sign = a_larger ? a_sign : b_sign;
        big_exp = a_larger ? a_exp : b_exp;
        exp_diff = a_larger ? (a_exp - b_exp) : (b_exp - a_exp);
        // Three spare low bits hold guard, round and sticky
        big_ext = a_larger ? {a_sig, 3'b000} : {b_sig, 3'b000};
        small_ext = a_larger ? {b_sig, 3'b000} : {a_sig, 3'b000};
        // Any set bit pushed out on the right folds into the sticky bit
        lost_mask = ~({27{1'b1}} << exp_diff);
        sticky = |(small_ext & lost_mask);
        small_aligned = (small_ext >> exp_diff) | {26'd0, sticky};
    end

    always_ff @(posedge clock) begin
        s1_sign <= big_sign;
        s1_eff_sub <= a_sign ^ b_sign;
        s1_exp <= big_exp;
        s1_big <= big_ext;
        s1_small <= small_aligned;
    end

    // The larger magnitude comes first, so a subtraction never goes negative
    always_ff @(posedge clock) begin
        s2_sign <= s1_sign;
        s2_exp <= s1_exp;
        if (s1_eff_sub) s2_sum <= {1'b0, s1_big} - {1'b0, s1_small};
        else s2_sum <= {1'b0, s1_big} + {1'b0, s1_small};
    end

    always_comb begin
        norm_shift = lead_zeros(s2_sum);
        norm_sum = s2_sum << norm_shift;
        // The hidden bit sits at bit 26 before a carry, hence the plus one
        norm_exp = {2'b00, s2_exp} + 10'd1 - {5'd0, norm_shift};
        norm_result.sign = s2_sign;
        norm_result.exponent = norm_exp[7:0];
        // Truncating the bits below the mantissa rounds toward zero
        norm_result.mantissa = norm_sum[26:4];
    end

    // Exact cancellation always gives +0
    always_ff @(posedge clock) begin
        s3_data <= (s2_sum == 28'd0) ? 32'd0 : norm_result;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= fire;
            for (int i = 1; i < add_latency; i++) valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clock) begin
        tag_q[0] <= a.tag;
        for (int i = 1; i < add_latency; i++) tag_q[i] <= tag_q[i-1];
    end

    assign result = '{valid: valid_q[add_latency-1],
                      data: s3_data,
                      tag: tag_q[add_latency-1]};

endmodule

`default_nettype wire

/* design/fp_alu.sv */
// Floating-point ALU for the execution stage of a small core
// Both operand streams fan out to four fixed-latency pipelines
// and each pipeline returns its result on a stream of its own

`timescale 1ns/1ns
`default_nettype none

module fp_alu (
    input  logic                         clock,
    input  logic                         rst_n,
    input  fp_alu_pkg::operand_stream_t  operand_a,
    input  fp_alu_pkg::operand_stream_t  operand_b,
    input  fp_alu_pkg::op_stream_t       operation,
    output fp_alu_pkg::result_stream_t   add_result,
    output fp_alu_pkg::result_stream_t   mul_result,
    output fp_alu_pkg::result_stream_t   fti_result,
    output fp_alu_pkg::result_stream_t   itf_result
);

    // Needs both operands and an operation, and tags with operand a
    fp_add_sub add_sub_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .a         (operand_a),
        .b         (operand_b),
        .operation (operation),
        .result    (add_result)
    );

    // Needs both operands and no operation
    fp_multiplier multiplier_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .a      (operand_a),
        .b      (operand_b),
        .result (mul_result)
    );

    // Operand b alone, read as a float
    fp_to_int fp_to_int_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .b      (operand_b),
        .result (fti_result)
    );

    // Operand a alone, read as an integer
    int_to_fp int_to_fp_i (
        .clock  (clock),
        .rst_n  (rst_n),
        .a      (operand_a),
        .result (itf_result)
    );

endmodule

`default_nettype wire

/* design/fp_alu_pkg.sv */
// Shared definitions for the floating-point ALU
// Holds the tag width, the pipeline latencies and the stream types
// that carry operands, operations and results between the blocks

`default_nettype none

package fp_alu_pkg;

    // Destination register address that travels with every item
    localparam int tag_width = 5;

    // Cycles from the firing edge to the result valid, per pipeline
    localparam int add_latency = 3;
    localparam int mul_latency = 2;
    localparam int fti_latency = 1;
    localparam int itf_latency = 2;

    // IEEE single-precision field layout
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] mantissa;
    } fp_fields_t;

    // An operand word is read as a float by some pipelines
    // and as a two's complement integer by int_to_fp
    typedef union packed {
        fp_fields_t         as_fp;
        logic signed [31:0] as_int;
    } operand_word_t;

    typedef struct packed {
        logic                 valid;
        operand_word_t        data;
        logic [tag_width-1:0] tag;
    } operand_stream_t;

    // Subtract set means a minus b, clear means a plus b
    typedef struct packed {
        logic valid;
        logic subtract;
    } op_stream_t;

    // Data is a float for add, mul and itf, and an integer for fti
    typedef struct packed {
        logic                 valid;
        logic [31:0]          data;
        logic [tag_width-1:0] tag;
    } result_stream_t;

endpackage

`default_nettype wire

/* design/fp_multiplier.sv */
// Floating-point multiplier, two pipeline stages
// Stage 1 forms sign, exponent and the full significand product
// Stage 2 normalizes by at most one place and truncates toward zero

`timescale 1ns/1ns
`default_nettype none

module fp_multiplier (
    input  logic                         clock,
    input  logic                         rst_n,
    input  fp_alu_pkg::operand_stream_t  a,
    input  fp_alu_pkg::operand_stream_t  b,
    output fp_alu_pkg::result_stream_t   result
);
    import fp_alu_pkg::*;

    logic fire;

    fp_fields_t  a_f, b_f;
    logic        prod_zero;
    logic        prod_sign;
    logic [9:0]  exp_sum;
    logic [47:0] product;

    // Stage 1 registers
    logic        s1_zero, s1_sign;
    logic [9:0]  s1_exp;
    logic [47:0] s1_prod;

    // Stage 2 normalization and output register
    fp_fields_t  norm_result;
    logic [9:0]  norm_exp;
    logic [31:0] s2_data;

    logic [mul_latency-1:0] valid_q;
    logic [tag_width-1:0]   tag_q [mul_latency];

    assign fire = a.valid & b.valid;

    always_comb begin
        a_f = a.data.as_fp;
        b_f = b.data.as_fp;
        // Zero and denormal operands both force the product to +0
        prod_zero = (a_f.exponent == 8'd0) || (b_f.exponent == 8'd0);
        prod_sign = a_f.sign ^ b_f.sign;
        // Both exponents carry the bias, so one bias comes off
        exp_sum = {2'b00, a_f.exponent} + {2'b00, b_f.exponent} - 10'd127;
        product = {1'b1, a_f.mantissa} * {1'b1, b_f.mantissa};
    end

    always_ff @(posedge clock) begin
        s1_zero <= prod_zero;
        s1_sign <= prod_sign;
        s1_exp <= exp_sum;
        s1_prod <= product;
    end

    // Two significands in [1,2) multiply to [1,4), so bit 47 picks the shift
    always_comb begin
        norm_exp = s1_prod[47] ? (s1_exp + 10'd1) : s1_exp;
        norm_result.sign = s1_sign;
        norm_result.exponent = norm_exp[7:0];
        norm_result.mantissa = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];
    end

    always_ff @(posedge clock) begin
        s2_data <= s1_zero ? 32'd0 : norm_result;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= fire;
            for (int i = 1; i < mul_latency; i++) valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clock) begin
        tag_q[0] <= a.tag;
        for (int i = 1; i < mul_latency; i++) tag_q[i] <= tag_q[i-1];
    end

    assign result = '{valid: valid_q[mul_latency-1],
                      data: s2_data,
                      tag: tag_q[mul_latency-1]};

endmodule

`default_nettype wire

/* design/fp_to_int.sv */
// Float to signed 32-bit integer converter, one pipeline stage
// Truncates toward zero and saturates at the signed limits

`timescale 1ns/1ns
`default_nettype none

module fp_to_int (
    input  logic                         clock,
    input  logic                         rst_n,
    input  fp_alu_pkg::operand_stream_t  b,
    output fp_alu_pkg::result_stream_t   result
);
    import fp_alu_pkg::*;

    fp_fields_t         b_f;
    logic signed [9:0]  unbiased;
    logic [54:0]        shifted;
    logic [30:0]        magnitude;
    logic [31:0]        int_value;
    logic [31:0]        s1_data;

    logic [fti_latency-1:0] valid_q;
    logic [tag_width-1:0]   tag_q [fti_latency];

    always_comb begin
        b_f = b.data.as_fp;
        unbiased = $signed({2'b00, b_f.exponent}) - 10'sd127;
        // The binary point of the shifted significand sits above bit 23
        shifted = {31'd0, 1'b1, b_f.mantissa} << unbiased[4:0];
        magnitude = shifted[53:23];
        // Denormals land here too, since their exponent is -127
        if (unbiased < 10'sd0) begin
            int_value = 32'd0;
        // From 2^31 up the value saturates, and -2^31 is also the negative limit
        end else if (unbiased >= 10'sd31) begin
            int_value = b_f.sign ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            int_value = b_f.sign ? -{1'b0, magnitude} : {1'b0, magnitude};
        end
    end

    always_ff @(posedge clock) begin
        s1_data <= int_value;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= b.valid;
            for (int i = 1; i < fti_latency; i++) valid_q[i] <= valid_q[i-1];
        end
    end

    // The integer result belongs to operand b's destination
    always_ff @(posedge clock) begin
        tag_q[0] <= b.tag;
        for (int i = 1; i < fti_latency; i++) tag_q[i] <= tag_q[i-1];
    end

    assign result = '{valid: valid_q[fti_latency-1],
                      data: s1_data,
                      tag: tag_q[fti_latency-1]};

endmodule

`default_nettype wire

/* design/int_to_fp.sv */
// Signed 32-bit integer to float converter, two pipeline stages
// Stage 1 takes the magnitude and its leading-zero count
// Stage 2 shifts, truncates to 24 significant bits and sets the exponent

`timescale 1ns/1ns
`default_nettype none

module int_to_fp (
    input  logic                         clock,
    input  logic                         rst_n,
    input  fp_alu_pkg::operand_stream_t  a,
    output fp_alu_pkg::result_stream_t   result
);
    import fp_alu_pkg::*;

    // Leading zeros of a 32-bit word, 32 for a zero word
    function automatic logic [5:0] lead_zeros(input logic [31:0] value);
        logic [5:0] count;
        logic       found;
        count = 6'd0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!found) begin
                if (value[i]) found = 1'b1;
                else count = count + 6'd1;
            end
        end
        return count;
    endfunction

    logic [31:0] abs_value;

    logic        s1_sign;
    logic [31:0] s1_abs;
    logic [5:0]  s1_lz;

    logic [31:0] norm_abs;
    fp_fields_t  norm_result;
    logic [31:0] s2_data;

    logic [itf_latency-1:0] valid_q;
    logic [tag_width-1:0]   tag_q [itf_latency];

    // Negating -2^31 wraps to itself, which is the right unsigned magnitude
    assign abs_value = a.data.as_int[31] ? -a.data.as_int : a.data.as_int;

    always_ff @(posedge clock) begin
        s1_sign <= a.data.as_int[31];
        s1_abs <= abs_value;
        s1_lz <= lead_zeros(abs_value);
    end

    always_comb begin
        // The top set bit moves to bit 31 and becomes the hidden bit
        norm_abs = s1_abs << s1_lz;
        norm_result.sign = s1_sign;
        // A top bit at position 31 means 2^31, biased to 158
        norm_result.exponent = 8'd158 - {2'b00, s1_lz};
        norm_result.mantissa = norm_abs[30:8];
    end

    always_ff @(posedge clock) begin
        s2_data <= (s1_abs == 32'd0) ? 32'd0 : norm_result;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= a.valid;
            for (int i = 1; i < itf_latency; i++) valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clock) begin
        tag_q[0] <= a.tag;
        for (int i = 1; i < itf_latency; i++) tag_q[i] <= tag_q[i-1];
    end

    assign result = '{valid: valid_q[itf_latency-1],
                      data: s2_data,
                      tag: tag_q[itf_latency-1]};

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compiles the fp_alu testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert -Wno-fatal --top-module fp_alu_tb \
    -f sim.f --Mdir "$build_dir" -o fp_alu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/fp_alu_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi

# The log decides the outcome
if grep -q "^Finished with no errors$" "$log_file"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* sim.f */
design/fp_alu_pkg.sv
design/fp_add_sub.sv
design/fp_multiplier.sv
design/fp_to_int.sv
design/int_to_fp.sv
design/fp_alu.sv
tb/fp_alu_checker.sv
tb/fp_alu_tb.sv

/* tb/fp_alu_checker.sv */
// Assertions bound into the floating-point ALU
// Checks that results stay quiet in reset and that each result valid
// follows its firing condition after the pipeline's fixed latency

`timescale 1ns/1ns
`default_nettype none

module fp_alu_checker (
    input logic                         clock,
    input logic                         rst_n,
    input fp_alu_pkg::operand_stream_t  operand_a,
    input fp_alu_pkg::operand_stream_t  operand_b,
    input fp_alu_pkg::op_stream_t       operation,
    input fp_alu_pkg::result_stream_t   add_result,
    input fp_alu_pkg::result_stream_t   mul_result,
    input fp_alu_pkg::result_stream_t   fti_result,
    input fp_alu_pkg::result_stream_t   itf_result
);
    import fp_alu_pkg::*;

    // Number of assertion failures so far
    int unsigned failures = 0;

    logic add_fire;
    logic mul_fire;

    assign add_fire = operand_a.valid & operand_b.valid & operation.valid;
    assign mul_fire = operand_a.valid & operand_b.valid;

    reset_quiet: assert property (@(posedge clock) !rst_n |->
        !(add_result.valid || mul_result.valid || fti_result.valid || itf_result.valid))
        else begin
            failures++;
            $error("a result valid is high while reset is held");
        end

    add_timing: assert property (@(posedge clock) disable iff (!rst_n)
        add_result.valid == $past(add_fire, add_latency))
        else begin
            failures++;
            $error("add result valid does not follow its issue");
        end

    mul_timing: assert property (@(posedge clock) disable iff (!rst_n)
        mul_result.valid == $past(mul_fire, mul_latency))
        else begin
            failures++;
            $error("mul result valid does not follow its issue");
        end

    // The converters each fire on one operand stream alone
    fti_timing: assert property (@(posedge clock) disable iff (!rst_n)
        fti_result.valid == $past(operand_b.valid, fti_latency))
        else begin
            failures++;
            $error("fti result valid does not follow operand b");
        end

    itf_timing: assert property (@(posedge clock) disable iff (!rst_n)
        itf_result.valid == $past(operand_a.valid, itf_latency))
        else begin
            failures++;
            $error("itf result valid does not follow operand a");
        end

endmodule

bind fp_alu fp_alu_checker checker_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .operation  (operation),
    .add_result (add_result),
    .mul_result (mul_result),
    .fti_result (fti_result),
    .itf_result (itf_result)
);

`default_nettype wire

/* tb/fp_alu_tb.sv */
// Testbench for the floating-point ALU
// Drives random operand and operation streams from a fixed seed and checks
// all four result streams against a reference model built on real arithmetic

`timescale 1ns/1ns
`default_nettype none

module fp_alu_tb;
    import fp_alu_pkg::*;

    // Random issue cycles, then a bound on the cycles allowed to drain
    localparam int issue_cycles = 3000;
    localparam int drain_limit = 20;

    logic            clock;
    logic            rst_n;
    operand_stream_t operand_a;
    operand_stream_t operand_b;
    op_stream_t      operation;
    result_stream_t  add_result;
    result_stream_t  mul_result;
    result_stream_t  fti_result;
    result_stream_t  itf_result;

    integer seed;

    // Expected results per stream, oldest issue at the front
    result_stream_t add_q[$];
    result_stream_t mul_q[$];
    result_stream_t fti_q[$];
    result_stream_t itf_q[$];

    fp_alu dut_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .operation  (operation),
        .add_result (add_result),
        .mul_result (mul_result),
        .fti_result (fti_result),
        .itf_result (itf_result)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic int unsigned random_below(input int unsigned limit);
        logic [31:0] word;
        word = $random(seed);
        return word % limit;
    endfunction

    // Normal exponents from 115 up to top_exp, now and then a zero or denormal
    function automatic logic [31:0] random_float(input int unsigned top_exp);
        logic [31:0] word;
        logic [7:0]  exp_field;
        word = $random(seed);
        if (random_below(16) == 0) begin
            // Denormals read as zero too, so half of these keep a mantissa
            return {word[31], 8'd0, word[23] ? word[22:0] : 23'd0};
        end
        exp_field = 8'd115 + 8'(random_below(top_exp - 114));
        return {word[31], exp_field, word[22:0]};
    endfunction

    // Single-precision bits to real, with zero and denormal read as zero
    function automatic real float_to_real(input logic [31:0] bits);
        logic [10:0] wide_exp;
        if (bits[30:23] == 8'd0) begin
            return 0.0;
        end
        // Rebias from 127 to 1023 and pad the mantissa out to 52 bits
        wide_exp = {3'b000, bits[30:23]} + 11'd896;
        return $bitstoreal({bits[31], wide_exp, bits[22:0], 29'd0});
    endfunction

    // Drops the low 29 mantissa bits of a double, which truncates toward zero
    function automatic logic [31:0] real_to_float(input real value);
        logic [63:0] wide;
        logic [10:0] narrow_exp;
        if (value == 0.0) begin
            return 32'd0;
        end
        wide = $realtobits(value);
        narrow_exp = wide[62:52] - 11'd896;
        return {wide[63], narrow_exp[7:0], wide[51:29]};
    endfunction

    function automatic logic [31:0] saturate_to_int(input real value);
        if (value >= 2147483648.0) return 32'h7fff_ffff;
        if (value <= -2147483648.0) return 32'h8000_0000;
        return $rtoi(value);
    endfunction

    task automatic stop_on_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_result(input string name, input result_stream_t got,
                                input result_stream_t want);
        compare_value({name, " data"}, got.data, want.data);
        compare_value({name, " tag"}, 32'(got.tag), 32'(want.tag));
    endtask

    task automatic report_unexpected(input string name);
        $display("an %s result appeared at %0t ns with no issue waiting for it", name, $time);
        stop_on_failure();
    endtask

    task automatic report_missing(input string name, input int count);
        $display("timeout: the %s stream never produced %0d issued results", name, count);
        stop_on_failure();
    endtask

    // Called on the edge where the DUT samples the inputs driven one edge earlier
    task automatic record_expected();
        result_stream_t entry;
        real            a_real;
        real            b_real;
        entry.valid = 1'b1;
        a_real = float_to_real(operand_a.data);
        b_real = float_to_real(operand_b.data);
        entry.tag = operand_a.tag;
        if (operand_a.valid && operand_b.valid && operation.valid) begin
            entry.data = real_to_float(operation.subtract ? a_real - b_real : a_real + b_real);
            add_q.push_back(entry);
        end
        if (operand_a.valid && operand_b.valid) begin
            entry.data = real_to_float(a_real * b_real);
            mul_q.push_back(entry);
        end
        if (operand_a.valid) begin
            entry.data = real_to_float($itor(operand_a.data.as_int));
            itf_q.push_back(entry);
        end
        // The integer conversion answers to operand b's destination
        if (operand_b.valid) begin
            entry.data = saturate_to_int(b_real);
            entry.tag = operand_b.tag;
            fti_q.push_back(entry);
        end
    endtask

    task automatic drive_next(input bit active);
        logic        a_valid;
        logic        b_valid;
        logic        op_valid;
        logic [31:0] a_word;
        logic [31:0] b_word;
        logic [31:0] tags;
        int unsigned pick;
        a_valid = active && (random_below(4) != 0);
        b_valid = active && (random_below(4) != 0);
        op_valid = active && (random_below(4) != 0);
        tags = $random(seed);
        // Large b exponents only where the adder cannot fire, so sums stay exact
        if (a_valid && op_valid) begin
            b_word = random_float(140);
        end else begin
            pick = random_below(8);
            if (pick == 0) b_word = 32'hcf00_0000;
            else if (pick == 1) b_word = 32'h4eff_ffff;
            else b_word = random_float(160);
        end
        // Without b neither adder nor multiplier fires, so a is a free integer
        if (b_valid) begin
            a_word = random_float(140);
        end else begin
            pick = random_below(8);
            if (pick == 0) a_word = 32'd0;
            else if (pick == 1) a_word = 32'h8000_0000;
            else if (pick == 2) a_word = random_float(140);
            else a_word = $random(seed);
        end
        operand_a <= {a_valid, a_word, tags[4:0]};
        operand_b <= {b_valid, b_word, tags[9:5]};
        operation <= {op_valid, tags[10]};
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((add_q.size() + mul_q.size() + fti_q.size() + itf_q.size()) > 0
               && waited < drain_limit) begin
            @(negedge clock);
            waited++;
        end
        if (add_q.size() > 0) report_missing("adder", add_q.size());
        if (mul_q.size() > 0) report_missing("multiplier", mul_q.size());
        if (fti_q.size() > 0) report_missing("float to integer", fti_q.size());
        if (itf_q.size() > 0) report_missing("integer to float", itf_q.size());
    endtask

    // Outputs settle after the rising edge and are read half a cycle later
    always @(negedge clock) begin
        if (rst_n) begin
            if (add_result.valid) begin
                if (add_q.size() == 0) report_unexpected("add");
                else check_result("add", add_result, add_q.pop_front());
            end
            if (mul_result.valid) begin
                if (mul_q.size() == 0) report_unexpected("mul");
                else check_result("mul", mul_result, mul_q.pop_front());
            end
            if (fti_result.valid) begin
                if (fti_q.size() == 0) report_unexpected("fti");
                else check_result("fti", fti_result, fti_q.pop_front());
            end
            if (itf_result.valid) begin
                if (itf_q.size() == 0) report_unexpected("itf");
                else check_result("itf", itf_result, itf_q.pop_front());
            end
        end
    end

    initial begin
        seed = 32'h93a4;
        rst_n = 1'b0;
        operand_a = '0;
        operand_b = '0;
        operation = '0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        for (int cycle = 0; cycle < issue_cycles; cycle++) begin
            @(posedge clock);
            record_expected();
            drive_next(1'b1);
        end
        // One more edge issues the last random inputs, then all valids drop
        @(posedge clock);
        record_expected();
        drive_next(1'b0);
        wait_for_drain();
        // Idle cycles in which any stray result would show up
        repeat (4) @(negedge clock);
        if (dut_i.checker_i.failures == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("%0d bound assertion failures were reported", dut_i.checker_i.failures);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire
